/* rtl/cop_settings.svh */
// Build-time sizes for the cop_lite coprocessor.
// Include wherever a width or the register count is needed; the
// guard makes repeated inclusion harmless.

`ifndef COP_SETTINGS_SVH
`define COP_SETTINGS_SVH

// Data path width, one GPR or CPR word
`define COP_XLEN 32

// Size of the private CPR bank
`define COP_NUM_CPRS 16

`endif

/* rtl/cop_pkg.sv */
// Shared types for cop_lite.
// Vector typedefs, opcode/result/state enums and the uop and response
// structs. Modules pull these in with a wildcard import in their header.

`include "cop_settings.svh"

package cop_pkg;

    typedef logic [`COP_XLEN-1:0]              word_t;      // One data word
    typedef logic [$clog2(`COP_NUM_CPRS)-1:0]  cpr_addr_t;  // CPR index
    typedef logic [4:0]                        gpr_addr_t;  // GPR index
    typedef logic [31:0]                       insn_t;      // Encoded instruction

    typedef enum logic [3:0] {
        OP_MV2COP = 4'd1,   // GPR -> CPR
        OP_MV2GPR = 4'd2,   // CPR -> GPR
        OP_ADD    = 4'd3,
        OP_SUB    = 4'd4,
        OP_XOR    = 4'd5,
        OP_ROTL   = 4'd6    // Multi-cycle
    } cop_op_t;

    typedef enum logic [2:0] {
        RES_OK     = 3'd0,
        RES_BAD_OP = 3'd1
    } cop_result_t;

    typedef enum logic [1:0] {
        S_IDLE,             // Waiting for a request
        S_EXEC,             // ALU running
        S_RSP               // Holding the response
    } seq_state_t;

    typedef struct packed {
        cop_op_t     op;
        logic        illegal;   // Opcode outside the known set
        cpr_addr_t   crd;
        cpr_addr_t   crs1;
        cpr_addr_t   crs2;
        gpr_addr_t   rd;
        word_t       rs1;       // GPR value from the host
    } cop_uop_t;

    typedef struct packed {
        cop_result_t result;
        logic        wen;       // GPR write back requested
        gpr_addr_t   waddr;
        word_t       wdata;
    } cop_rsp_t;

endpackage

/* rtl/cop_decode.sv */
// Instruction decoder.
// Purely combinational. Slices the instruction fields into a uop and
// flags opcodes outside the supported set. Output is only meaningful
// while the host holds a request.

module cop_decode import cop_pkg::*; (
    input  insn_t    insn_enc,  // Instruction from host
    input  word_t    rs1,       // GPR source value
    output cop_uop_t uop        // Decoded micro-op
);

    logic [3:0] opc_raw;        // Raw opcode field
    logic       opc_known;      // Opcode in supported set

    assign opc_raw = insn_enc[3:0];

    always_comb begin
        case (opc_raw)
            OP_MV2COP,
            OP_MV2GPR,
            OP_ADD,
            OP_SUB,
            OP_XOR,
            OP_ROTL:  opc_known = 1'b1;
            default:  opc_known = 1'b0;    // Reserved encodings
        endcase
    end

    always_comb begin
        uop.op      = cop_op_t'(opc_raw);   // Kept even if illegal
        uop.illegal = !opc_known;
        uop.crd     = insn_enc[7:4];        // Destination CPR
        uop.crs1    = insn_enc[11:8];       // Source A
        uop.crs2    = insn_enc[15:12];      // Source B / rotate amount reg
        uop.rd      = insn_enc[20:16];      // GPR target
        uop.rs1     = rs1;
    end

endmodule

/* rtl/cop_cpr_file.sv */
// Coprocessor register bank.
// Two combinational read ports and one synchronous write port.
// All entries return to zero on reset so the host sees a clean bank.

`include "cop_settings.svh"

module cop_cpr_file import cop_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,     // Sync, active low
    input  cpr_addr_t raddr_a,      // Port A address
    output word_t     rdata_a,      // Port A data
    input  cpr_addr_t raddr_b,      // Port B address
    output word_t     rdata_b,      // Port B data
    input  logic      wen,          // Write strobe
    input  cpr_addr_t waddr,
    input  word_t     wdata
);

    word_t cprs [`COP_NUM_CPRS];    // The bank

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NUM_CPRS; i++) begin
                cprs[i] <= '0;      // Clear every CPR
            end
        end else if (wen) begin
            cprs[waddr] <= wdata;
        end
    end

    assign rdata_a = cprs[raddr_a]; // Async read
    assign rdata_b = cprs[raddr_b];

    // Sequencer must always drive a clean write strobe once out of reset
    a_wen_known: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        !$isunknown(wen)
    ) else $error("CPR write enable is unknown");

endmodule

/* rtl/cop_alu.sv */
// Execution unit.
// Single-cycle ops finish one cycle after start. ROTL rotates the
// operand one bit per cycle, counting down from opb[4:0], and signals
// done once the count reaches zero. Result holds until the next start.

`include "cop_settings.svh"

module cop_alu import cop_pkg::*; (
    input  logic     g_clk,
    input  logic     g_resetn,      // Sync, active low
    input  logic     start,         // One-cycle pulse from sequencer
    input  cop_uop_t uop,           // Latched micro-op
    input  word_t    opa,           // CPR[crs1]
    input  word_t    opb,           // CPR[crs2]
    output logic     done,
    output word_t    result
);

    localparam int ROT_W = $clog2(`COP_XLEN);  // Rotate amount bits

    logic             rot_start;    // Start of a rotate
    logic             rot_busy;     // Rotate in progress
    logic [ROT_W-1:0] rot_cnt;      // Bits left to rotate
    logic             plain_done;   // Single-cycle op finished
    word_t            plain_res;    // Combinational result
    word_t            acc;          // Result / rotate register

    assign rot_start = start && (uop.op == OP_ROTL);

    always_comb begin
        case (uop.op)
            OP_MV2COP: plain_res = uop.rs1;
            OP_MV2GPR: plain_res = opa;
            OP_ADD:    plain_res = opa + opb;
            OP_SUB:    plain_res = opa - opb;
            OP_XOR:    plain_res = opa ^ opb;
            OP_ROTL:   plain_res = opa;     // Seed for the rotator
            default:   plain_res = '0;      // Result unused for illegal ops
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rot_busy   <= 1'b0;
            rot_cnt    <= '0;
            plain_done <= 1'b0;
        end else begin
            plain_done <= start && !rot_start;
            if (rot_start) begin
                rot_busy <= 1'b1;
                rot_cnt  <= opb[ROT_W-1:0];     // Amount from crs2
            end else if (rot_busy && rot_cnt == '0) begin
                rot_busy <= 1'b0;               // Done this cycle
            end else if (rot_busy) begin
                rot_cnt  <= rot_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (start) begin
            acc <= plain_res;
        end else if (rot_busy && rot_cnt != '0) begin
            acc <= {acc[`COP_XLEN-2:0], acc[`COP_XLEN-1]};  // One bit left
        end
    end

    assign done   = plain_done | (rot_busy && rot_cnt == '0);
    assign result = acc;

    // Sequencer may only start the next op after the rotate drains
    a_no_start_busy: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        rot_busy |-> !start
    ) else $error("ALU started while rotate in progress");

endmodule

/* rtl/cop_sequencer.sv */
// Control FSM for one instruction at a time.
// S_IDLE accepts a request and latches the uop, S_EXEC pulses the ALU
// start and waits for done, then writes the CPR and loads the response.
// S_RSP holds the response until the host acknowledges it.

module cop_sequencer import cop_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,     // Sync, active low
    input  logic      insn_req,     // Host has an instruction
    output logic      insn_ack,     // Ready to accept
    input  cop_uop_t  uop,          // From decoder
    output cop_uop_t  exec_uop,     // Latched copy for the datapath
    output logic      alu_start,
    input  logic      alu_done,
    input  word_t     alu_result,
    output logic      cpr_wen,
    output cpr_addr_t cpr_waddr,
    output word_t     cpr_wdata,
    output logic      rsp_req,      // Response valid
    input  logic      rsp_ack,      // Host took it
    output cop_rsp_t  rsp
);

    seq_state_t state;
    logic       start_q;            // First cycle of S_EXEC
    cop_rsp_t   rsp_q;              // Held response
    cop_rsp_t   rsp_next;           // Built from the finished op
    logic       is_mv2gpr;

    assign insn_ack  = (state == S_IDLE);
    assign rsp_req   = (state == S_RSP);
    assign alu_start = start_q;
    assign rsp       = rsp_q;
    assign is_mv2gpr = (exec_uop.op == OP_MV2GPR);

    always_comb begin
        rsp_next.result = exec_uop.illegal ? RES_BAD_OP : RES_OK;
        rsp_next.wen    = !exec_uop.illegal && is_mv2gpr;  // GPR writeback only
        rsp_next.waddr  = exec_uop.rd;
        rsp_next.wdata  = alu_result;
    end

    // CPR write lands on the same edge rsp_req rises
    assign cpr_wen   = (state == S_EXEC) && alu_done && !exec_uop.illegal && !is_mv2gpr;
    assign cpr_waddr = exec_uop.crd;
    assign cpr_wdata = alu_result;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state   <= S_IDLE;
            start_q <= 1'b0;
            rsp_q   <= '0;              // wen low out of reset
        end else begin
            start_q <= 1'b0;
            case (state)
                S_IDLE: if (insn_req) begin
                    state   <= S_EXEC;
                    start_q <= 1'b1;
                end
                S_EXEC: if (alu_done) begin
                    state <= S_RSP;
                    rsp_q <= rsp_next;
                end
                S_RSP:   if (rsp_ack) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_req && insn_ack) begin
            exec_uop <= uop;            // Capture on request transfer
        end
    end

    // Response frozen until the host accepts it
    a_rsp_stable: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        rsp_req && !rsp_ack |=> rsp_req && $stable(rsp)
    ) else $error("response changed before acknowledge");

endmodule

/* rtl/cop_top.sv */
// cop_lite top level.
// Connects decoder, sequencer, CPR bank and ALU. The host sees a
// req/ack pair for instructions and another for responses.

module cop_top import cop_pkg::*; (
    input  logic     g_clk,
    input  logic     g_resetn,      // Sync, active low
    input  logic     insn_req,      // Instruction request
    output logic     insn_ack,      // Instruction accepted
    input  insn_t    insn_enc,      // Encoded instruction
    input  word_t    rs1,           // GPR source
    output logic     rsp_req,       // Response valid
    input  logic     rsp_ack,       // Response accepted
    output cop_rsp_t rsp            // Result and GPR write
);

    cop_uop_t  dec_uop;             // Decoder output
    cop_uop_t  exec_uop;            // Latched uop
    logic      alu_start;
    logic      alu_done;
    word_t     alu_result;
    word_t     opa;                 // CPR[crs1]
    word_t     opb;                 // CPR[crs2]
    logic      cpr_wen;
    cpr_addr_t cpr_waddr;
    word_t     cpr_wdata;

    cop_decode u_decode (
        .insn_enc (insn_enc),
        .rs1      (rs1),
        .uop      (dec_uop)
    );

    cop_sequencer u_seq (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .insn_req   (insn_req),
        .insn_ack   (insn_ack),
        .uop        (dec_uop),
        .exec_uop   (exec_uop),
        .alu_start  (alu_start),
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .cpr_wen    (cpr_wen),
        .cpr_waddr  (cpr_waddr),
        .cpr_wdata  (cpr_wdata),
        .rsp_req    (rsp_req),
        .rsp_ack    (rsp_ack),
        .rsp        (rsp)
    );

    cop_cpr_file u_cprs (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .raddr_a  (exec_uop.crs1),  // Read at latched sources
        .rdata_a  (opa),
        .raddr_b  (exec_uop.crs2),
        .rdata_b  (opb),
        .wen      (cpr_wen),
        .waddr    (cpr_waddr),
        .wdata    (cpr_wdata)
    );

    cop_alu u_alu (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .start    (alu_start),
        .uop      (exec_uop),
        .opa      (opa),
        .opb      (opb),
        .done     (alu_done),
        .result   (alu_result)
    );

endmodule

/* sim/tb_cop.sv */
// Testbench for cop_lite.
// Issues random instruction streams over the host handshakes, predicts
// every response from a CPR model kept here, and checks it on transfer.
// Random response acknowledge delays exercise the back-pressure rules.

`include "cop_settings.svh"

module tb_cop import cop_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 3;
    localparam int INSN_LIMIT   = 180;    // Upper bound on instructions in all tests
    localparam int CYC_PER_INSN = 40;     // Worst rotate plus handshakes

    logic     g_clk;
    logic     g_resetn;
    logic     insn_req;
    logic     insn_ack;
    insn_t    insn_enc;
    word_t    rs1;
    logic     rsp_req;
    logic     rsp_ack;
    cop_rsp_t rsp;

    word_t    model [`COP_NUM_CPRS];      // Expected CPR contents
    integer   seed;
    int       errors;                     // Whole run
    int       test_errs;                  // Current test
    int       n_insns;
    int       n_tests;
    string    test_name;

    cop_top uut (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .insn_req (insn_req),
        .insn_ack (insn_ack),
        .insn_enc (insn_enc),
        .rs1      (rs1),
        .rsp_req  (rsp_req),
        .rsp_ack  (rsp_ack),
        .rsp      (rsp)
    );

    always #2 g_clk = ~g_clk;             // 4 ns period

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic cpr_addr_t rand_cpr();
        return $unsigned($random(seed)) % `COP_NUM_CPRS;
    endfunction

    function automatic gpr_addr_t rand_gpr();
        return $unsigned($random(seed)) % 32;
    endfunction

    function automatic logic [3:0] rand_illegal();
        int v;
        v = $unsigned($random(seed)) % 10;
        return (v == 0) ? 4'd0 : 4'(v + 6);   // 0 or 7..15
    endfunction

    function automatic word_t rotl_model(word_t v, int n);
        return (v << n) | (v >> (`COP_XLEN - n));   // n = 0 leaves v as is
    endfunction

    task automatic report_failure(string what);
        $display("Error: %s: %s", test_name, what);
        errors++;
        test_errs++;
    endtask

    task automatic compare_result(cop_result_t exp, cop_result_t act);
        if (act !== exp) begin
            $display("Error: %s: result expected %0d actual %0d", test_name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic compare_write(logic exp_wen, gpr_addr_t exp_addr, word_t exp_data,
                                 logic act_wen, gpr_addr_t act_addr, word_t act_data);
        if (act_wen !== exp_wen ||
            (exp_wen && {act_addr, act_data} !== {exp_addr, exp_data})) begin
            $display("Error: %s: write expected wen=%0b x%0d=%h actual wen=%0b x%0d=%h",
                     test_name, exp_wen, exp_addr, exp_data, act_wen, act_addr, act_data);
            errors++;
            test_errs++;
        end
    endtask

    // One instruction end to end, starting just past a rising edge
    task automatic issue(logic [3:0] opc, cpr_addr_t crd, cpr_addr_t crs1,
                         cpr_addr_t crs2, gpr_addr_t rd, word_t src);
        cop_result_t exp_res;
        logic        exp_wen;
        word_t       exp_data;
        word_t       exp_cpr;
        logic        cpr_upd;
        cop_rsp_t    held;
        int          delay;
        exp_res  = RES_OK;
        exp_wen  = 1'b0;
        exp_data = '0;
        exp_cpr  = '0;
        cpr_upd  = 1'b1;
        case (opc)
            OP_MV2COP: exp_cpr = src;
            OP_MV2GPR: begin
                exp_wen  = 1'b1;
                exp_data = model[crs1];
                cpr_upd  = 1'b0;
            end
            OP_ADD:    exp_cpr = model[crs1] + model[crs2];
            OP_SUB:    exp_cpr = model[crs1] - model[crs2];
            OP_XOR:    exp_cpr = model[crs1] ^ model[crs2];
            OP_ROTL:   exp_cpr = rotl_model(model[crs1], model[crs2][4:0]);
            default: begin
                exp_res = RES_BAD_OP;         // Nothing written anywhere
                cpr_upd = 1'b0;
            end
        endcase
        insn_req <= 1'b1;
        insn_enc <= {11'(rand_word()), rd, crs2, crs1, crd, opc};  // Upper bits junk
        rs1      <= src;
        @(posedge g_clk);
        while (!insn_ack) begin
            if (rsp_req) report_failure("response raised before the request was taken");
            @(posedge g_clk);
        end
        insn_req <= 1'b0;                     // Transfer on this edge
        @(posedge g_clk);
        while (!rsp_req) begin
            if (insn_ack) report_failure("insn_ack high while the instruction executes");
            @(posedge g_clk);
        end
        held  = rsp;
        delay = $unsigned($random(seed)) % 4;
        if (insn_ack) report_failure("insn_ack high while a response is pending");
        for (int i = 0; i <= delay; i++) begin
            if (i == delay) rsp_ack <= 1'b1;
            @(posedge g_clk);
            if (!rsp_req || insn_ack || rsp !== held)
                report_failure("response or handshake changed before rsp_ack");
        end
        rsp_ack <= 1'b0;
        compare_result(exp_res, held.result);
        compare_write(exp_wen, rd, exp_data, held.wen, held.waddr, held.wdata);
        if (cpr_upd) model[crd] = exp_cpr;
        n_insns++;
    endtask

    task automatic read_back_all();
        for (int r = 0; r < `COP_NUM_CPRS; r++)
            issue(OP_MV2GPR, rand_cpr(), cpr_addr_t'(r), rand_cpr(), rand_gpr(), rand_word());
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        n_tests++;
        $display("Test %-16s done, %0d errors", test_name, test_errs);
    endtask

    // Watchdog sized from the instruction budget
    initial begin
        repeat (RESET_CYCLES + INSN_LIMIT * CYC_PER_INSN) @(posedge g_clk);
        $display("Timeout: the DUT stopped answering within the cycle budget");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        g_clk     = 1'b0;
        g_resetn  = 1'b0;
        insn_req  = 1'b0;
        rsp_ack   = 1'b0;
        insn_enc  = '0;
        rs1       = '0;
        seed      = 17392;
        errors    = 0;
        n_insns   = 0;
        n_tests   = 0;
        for (int i = 0; i < `COP_NUM_CPRS; i++) model[i] = '0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(posedge g_clk);

        start_test("reset_state");
        if (insn_ack !== 1'b1 || rsp_req !== 1'b0)
            report_failure("handshake not idle after reset");
        read_back_all();                      // Every CPR must read zero
        end_test();

        start_test("move_roundtrip");
        for (int k = 0; k < 8; k++) begin
            cpr_addr_t a;
            a = rand_cpr();
            issue(OP_MV2COP, a, rand_cpr(), rand_cpr(), rand_gpr(), rand_word());
            issue(OP_MV2GPR, rand_cpr(), a, rand_cpr(), rand_gpr(), rand_word());
        end
        end_test();

        start_test("alu_random");
        for (int r = 0; r < `COP_NUM_CPRS; r++)
            issue(OP_MV2COP, cpr_addr_t'(r), rand_cpr(), rand_cpr(), rand_gpr(), rand_word());
        for (int k = 0; k < 30; k++)
            issue(4'(OP_ADD + $unsigned($random(seed)) % 3), rand_cpr(), rand_cpr(),
                  rand_cpr(), rand_gpr(), rand_word());
        read_back_all();
        end_test();

        start_test("rotate");
        for (int k = 0; k < 10; k++) begin
            cpr_addr_t b;
            cpr_addr_t d;
            b = rand_cpr();
            d = rand_cpr();
            issue(OP_MV2COP, b, rand_cpr(), rand_cpr(), rand_gpr(), rand_word());  // Amount
            issue(OP_ROTL, d, rand_cpr(), b, rand_gpr(), rand_word());
            issue(OP_MV2GPR, rand_cpr(), d, rand_cpr(), rand_gpr(), rand_word());
        end
        end_test();

        start_test("illegal_ops");
        for (int k = 0; k < 10; k++)
            issue(rand_illegal(), rand_cpr(), rand_cpr(), rand_cpr(), rand_gpr(), rand_word());
        read_back_all();                      // Bank must be untouched
        end_test();

        start_test("backpressure");
        for (int k = 0; k < 20; k++) begin
            logic [3:0] opc;
            opc = ($unsigned($random(seed)) % 8 == 0) ? rand_illegal()
                                                      : 4'(1 + $unsigned($random(seed)) % 6);
            issue(opc, rand_cpr(), rand_cpr(), rand_cpr(), rand_gpr(), rand_word());
        end
        end_test();

        $display("Summary: %0d tests, %0d instructions, %0d errors", n_tests, n_insns, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* cop_lite.f */
+incdir+rtl
rtl/cop_pkg.sv
rtl/cop_decode.sv
rtl/cop_cpr_file.sv
rtl/cop_alu.sv
rtl/cop_sequencer.sv
rtl/cop_top.sv
sim/tb_cop.sv
